// File: hdl/dcache_pkg.sv
package dcache_pkg;

    // core side
    localparam int CORE_ADDR_W = 16;
    localparam int WORD_W      = 32;
    localparam int WORD_BYTES  = 4;

    // line and memory bus geometry
    localparam int LINE_BYTES     = 64;
    localparam int BEAT_W         = 128;
    localparam int BEATS_PER_LINE = 4;

    typedef logic [CORE_ADDR_W-1:0] core_addr_t;
    typedef logic [WORD_W-1:0]      word_t;
    typedef logic [BEAT_W-1:0]      beat_t;

    // memory address counts 16-byte beats
    typedef logic [CORE_ADDR_W-$clog2(BEAT_W/8)-1:0] beat_addr_t;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0]       beat_cnt_t;
    typedef logic [WORD_BYTES-1:0]                   byte_mask_t;

    typedef enum logic [1:0] {
        SIZE_BYTE,
        SIZE_HALF,
        SIZE_WORD
    } mem_size_t;

    typedef enum logic [1:0] {
        ST_READY,  // serving hits
        ST_MISS,   // line fill from memory
        ST_EVICT   // write-back of a dirty victim
    } cache_state_t;

endpackage

// File: hdl/dcache_array_if.sv
`timescale 1ns/1ps

interface dcache_array_if #(
    parameter int SETS = 8,
    parameter int WAYS = 2
);
    import dcache_pkg::*;

    localparam int IDX_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);
    localparam int TAG_W = CORE_ADDR_W - $clog2(LINE_BYTES) - IDX_W;

    // lookup of the request being accepted
    logic             lookup_en;
    core_addr_t       lookup_addr;
    logic             hit;
    logic [WAY_W-1:0] hit_way;
    logic [WAY_W-1:0] victim_way;
    logic             victim_dirty;
    logic [TAG_W-1:0] victim_tag;

    // store into a resident line
    logic             store_en;
    logic [WAY_W-1:0] store_way;
    core_addr_t       store_addr;
    mem_size_t        store_size;
    word_t            store_wdata;

    // fill beat from memory, also selects the victim line for write-back
    logic             fill_en;
    logic [WAY_W-1:0] fill_way;
    logic [IDX_W-1:0] fill_set;
    beat_cnt_t        fill_beat;
    beat_t            fill_data;
    logic             fill_last;
    logic [TAG_W-1:0] fill_tag;
    beat_cnt_t        victim_beat;
    beat_t            victim_data;

    // load read
    logic             rd_en;
    logic [WAY_W-1:0] rd_way;
    core_addr_t       rd_addr;
    mem_size_t        rd_size;
    logic             rd_unsigned;
    word_t            rd_data;

    modport ctrl (
        output lookup_en, lookup_addr,
        output store_en, store_way, store_addr, store_size, store_wdata,
        output fill_en, fill_way, fill_set, fill_beat, fill_data, fill_last, fill_tag,
        output rd_en, rd_way, rd_addr, rd_size, rd_unsigned, victim_beat,
        input  hit, hit_way, victim_way, victim_dirty, victim_tag, victim_data
    );

    modport tags (
        input  lookup_en, lookup_addr, store_en, store_way, store_addr,
        input  fill_way, fill_set, fill_last, fill_tag, rd_en, rd_way, rd_addr,
        output hit, hit_way, victim_way, victim_dirty, victim_tag
    );

    modport data (
        input  store_en, store_way, store_addr, store_size, store_wdata,
        input  fill_en, fill_way, fill_set, fill_beat, fill_data, victim_beat,
        input  rd_en, rd_way, rd_addr, rd_size, rd_unsigned,
        output rd_data, victim_data
    );

endinterface

// File: hdl/dcache_tags.sv
`timescale 1ns/1ps

module dcache_tags #(
    parameter int SETS = 8,
    parameter int WAYS = 2
) (
    input  logic         clk,
    input  logic         rst,
    dcache_array_if.tags arr
);
    import dcache_pkg::*;

    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);
    localparam int TAG_W = CORE_ADDR_W - OFF_W - IDX_W;

    logic             valid   [SETS][WAYS];
    logic             dirty   [SETS][WAYS];
    logic [TAG_W-1:0] tag_arr [SETS][WAYS];
    logic [WAY_W-1:0] lru     [SETS][WAYS];

    logic [IDX_W-1:0] lk_set;
    logic [TAG_W-1:0] lk_tag;
    logic             lk_match;
    logic [WAY_W-1:0] lk_hit_way;
    logic [WAY_W-1:0] lk_victim;

    logic             touch;
    logic [IDX_W-1:0] tch_set;
    logic [WAY_W-1:0] tch_way;

    // search every way of the set, victim is the way at the oldest LRU count
    always_comb begin
        lk_set     = arr.lookup_addr[OFF_W +: IDX_W];
        lk_tag     = arr.lookup_addr[CORE_ADDR_W-1 -: TAG_W];
        lk_match   = 1'b0;
        lk_hit_way = '0;
        lk_victim  = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid[lk_set][w] && (tag_arr[lk_set][w] == lk_tag)) begin
                lk_match   = 1'b1;
                lk_hit_way = WAY_W'(w);
            end
            if (lru[lk_set][w] == WAY_W'(WAYS - 1)) begin
                lk_victim = WAY_W'(w);
            end
        end
    end

    assign arr.hit          = arr.lookup_en && lk_match;
    assign arr.hit_way      = lk_hit_way;
    assign arr.victim_way   = lk_victim;
    assign arr.victim_dirty = dirty[lk_set][lk_victim];
    assign arr.victim_tag   = tag_arr[lk_set][lk_victim];

    // a read outside an acceptance cycle completes a load miss and leaves LRU alone
    assign touch   = arr.store_en || (arr.rd_en && arr.lookup_en);
    assign tch_set = arr.store_en ? arr.store_addr[OFF_W +: IDX_W]
                                  : arr.rd_addr[OFF_W +: IDX_W];
    assign tch_way = arr.store_en ? arr.store_way : arr.rd_way;

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < WAYS; w++) begin
                    valid[s][w] <= 1'b0;
                    dirty[s][w] <= 1'b0;
                    lru[s][w]   <= WAY_W'(w);
                end
            end
        end else begin
            if (arr.store_en) begin
                dirty[tch_set][arr.store_way] <= 1'b1;
            end
            if (arr.fill_last) begin
                valid[arr.fill_set][arr.fill_way] <= 1'b1;
                dirty[arr.fill_set][arr.fill_way] <= 1'b0;
            end
            if (touch) begin
                // younger ways age by one, touched way becomes the newest
                for (int w = 0; w < WAYS; w++) begin
                    if (lru[tch_set][w] < lru[tch_set][tch_way]) begin
                        lru[tch_set][w] <= lru[tch_set][w] + 1'b1;
                    end
                end
                lru[tch_set][tch_way] <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (arr.fill_last) begin
            tag_arr[arr.fill_set][arr.fill_way] <= arr.fill_tag;
        end
    end

endmodule

// File: hdl/dcache_data.sv
`timescale 1ns/1ps

module dcache_data #(
    parameter int SETS = 8,
    parameter int WAYS = 2
) (
    input  logic         clk,
    dcache_array_if.data arr
);
    import dcache_pkg::*;

    localparam int OFF_W    = $clog2(LINE_BYTES);
    localparam int IDX_W    = $clog2(SETS);
    localparam int WSEL_LSB = $clog2(WORD_BYTES);
    localparam int BSEL_LSB = $clog2(BEAT_W / 8);

    beat_t lines [SETS][WAYS][BEATS_PER_LINE];

    logic [IDX_W-1:0]             st_set;
    beat_cnt_t                    st_beat;
    logic [BSEL_LSB-WSEL_LSB-1:0] st_word;
    logic [WSEL_LSB-1:0]          st_off;
    byte_mask_t                   st_mask;
    word_t                        st_data;

    logic [IDX_W-1:0]             rd_set;
    beat_cnt_t                    rd_beat;
    logic [BSEL_LSB-WSEL_LSB-1:0] rd_word_sel;
    logic [WSEL_LSB-1:0]          rd_off;
    word_t                        rd_word;
    word_t                        rd_shift;
    word_t                        rd_ext;

    function automatic byte_mask_t size_mask(input mem_size_t size);
        case (size)
            SIZE_BYTE: return 4'b0001;
            SIZE_HALF: return 4'b0011;
            default:   return 4'b1111;
        endcase
    endfunction

    // store bytes are aligned to the address offset within the word
    assign st_set  = arr.store_addr[OFF_W +: IDX_W];
    assign st_beat = arr.store_addr[BSEL_LSB +: $bits(beat_cnt_t)];
    assign st_word = arr.store_addr[WSEL_LSB +: BSEL_LSB - WSEL_LSB];
    assign st_off  = arr.store_addr[WSEL_LSB-1:0];
    assign st_mask = size_mask(arr.store_size) << st_off;
    assign st_data = arr.store_wdata << (st_off * 8);

    always_ff @(posedge clk) begin
        if (arr.fill_en) begin
            lines[arr.fill_set][arr.fill_way][arr.fill_beat] <= arr.fill_data;
        end
        if (arr.store_en) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                if (st_mask[i]) begin
                    lines[st_set][arr.store_way][st_beat][(st_word * WORD_BYTES + i) * 8 +: 8]
                        <= st_data[i * 8 +: 8];
                end
            end
        end
    end

    // write-back reads the line that the fill will replace
    assign arr.victim_data = lines[arr.fill_set][arr.fill_way][arr.victim_beat];

    assign rd_set      = arr.rd_addr[OFF_W +: IDX_W];
    assign rd_beat     = arr.rd_addr[BSEL_LSB +: $bits(beat_cnt_t)];
    assign rd_word_sel = arr.rd_addr[WSEL_LSB +: BSEL_LSB - WSEL_LSB];
    assign rd_off      = arr.rd_addr[WSEL_LSB-1:0];

    always_comb begin
        rd_word  = lines[rd_set][arr.rd_way][rd_beat][rd_word_sel * WORD_W +: WORD_W];
        rd_shift = rd_word >> (rd_off * 8);
        case (arr.rd_size)
            SIZE_BYTE: rd_ext = {{24{!arr.rd_unsigned && rd_shift[7]}}, rd_shift[7:0]};
            SIZE_HALF: rd_ext = {{16{!arr.rd_unsigned && rd_shift[15]}}, rd_shift[15:0]};
            default:   rd_ext = rd_shift;
        endcase
    end

    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            arr.rd_data <= rd_ext;
        end
    end

endmodule

// File: hdl/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl #(
    parameter int SETS = 8,
    parameter int WAYS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  dcache_pkg::core_addr_t req_addr,
    input  dcache_pkg::word_t      req_wdata,
    input  dcache_pkg::mem_size_t  req_size,
    input  logic                   req_unsigned,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output logic                   mem_rd_valid,
    output dcache_pkg::beat_addr_t mem_rd_addr,
    output logic                   mem_wr_valid,
    output dcache_pkg::beat_addr_t mem_wr_addr,
    output dcache_pkg::beat_t      mem_wr_data,
    input  logic                   mem_rsp_valid,
    input  dcache_pkg::beat_t      mem_rsp_data,
    dcache_array_if.ctrl           arr
);
    import dcache_pkg::*;

    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(SETS);
    localparam int WAY_W = $clog2(WAYS);
    localparam int TAG_W = CORE_ADDR_W - OFF_W - IDX_W;
    localparam beat_cnt_t LAST_BEAT = beat_cnt_t'(BEATS_PER_LINE - 1);

    cache_state_t state;
    cache_state_t state_nx;
    logic         accept;
    logic         miss_start;

    // accepted request and its lookup results
    logic             r_valid;
    logic             r_hit;
    core_addr_t       r_addr;
    logic             r_write;
    word_t            r_wdata;
    mem_size_t        r_size;
    logic             r_unsigned;
    logic [WAY_W-1:0] r_victim_way;
    logic             r_victim_dirty;
    logic [TAG_W-1:0] r_victim_tag;
    beat_addr_t       r_wr_base;

    // pending miss, filled into the victim way
    core_addr_t       p_addr;
    logic             p_write;
    word_t            p_wdata;
    mem_size_t        p_size;
    logic             p_unsigned;
    logic [WAY_W-1:0] p_way;
    beat_addr_t       p_wr_base;
    beat_addr_t       p_rd_base;
    core_addr_t       cur_addr;

    beat_cnt_t wr_cnt;
    beat_cnt_t rd_req_cnt;
    beat_cnt_t rd_rsp_cnt;
    logic      rd_req_done;
    logic      fill_done;

    assign miss_start = (state == ST_READY) && r_valid && !r_hit;
    assign req_ready  = (state == ST_READY) && !miss_start;
    assign accept     = req_valid && req_ready;

    always_ff @(posedge clk) begin
        if (accept) begin
            r_hit          <= arr.hit;
            r_addr         <= req_addr;
            r_write        <= req_write;
            r_wdata        <= req_wdata;
            r_size         <= req_size;
            r_unsigned     <= req_unsigned;
            r_victim_way   <= arr.victim_way;
            r_victim_dirty <= arr.victim_dirty;
            r_victim_tag   <= arr.victim_tag;
        end
        if (miss_start) begin
            p_addr     <= r_addr;
            p_write    <= r_write;
            p_wdata    <= r_wdata;
            p_size     <= r_size;
            p_unsigned <= r_unsigned;
            p_way      <= r_victim_way;
            p_wr_base  <= r_wr_base;
        end
    end

    assign r_wr_base = {r_victim_tag, r_addr[OFF_W +: IDX_W], beat_cnt_t'(0)};
    assign p_rd_base = {p_addr[CORE_ADDR_W-1:OFF_W], beat_cnt_t'(0)};

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= ST_READY;
            r_valid     <= 1'b0;
            rsp_valid   <= 1'b0;
            fill_done   <= 1'b0;
            rd_req_done <= 1'b0;
            wr_cnt      <= '0;
            rd_req_cnt  <= '0;
            rd_rsp_cnt  <= '0;
        end else begin
            state     <= state_nx;
            r_valid   <= accept;
            rsp_valid <= arr.rd_en;
            fill_done <= arr.fill_last;
            if (mem_wr_valid) begin
                wr_cnt <= wr_cnt + 1'b1;
            end
            if (mem_rd_valid) begin
                rd_req_cnt <= rd_req_cnt + 1'b1;
            end
            if (mem_rsp_valid) begin
                rd_rsp_cnt <= rd_rsp_cnt + 1'b1;
            end
            if (mem_rd_valid && (rd_req_cnt == LAST_BEAT)) begin
                rd_req_done <= 1'b1;
            end else if (fill_done) begin
                rd_req_done <= 1'b0;
            end
        end
    end

    always_comb begin
        state_nx = state;
        case (state)
            ST_READY: begin
                if (miss_start) begin
                    state_nx = r_victim_dirty ? ST_EVICT : ST_MISS;
                end
            end
            ST_EVICT: begin
                if (wr_cnt == LAST_BEAT) begin
                    state_nx = ST_MISS;
                end
            end
            // one extra cycle after the last beat for the load read or store merge
            ST_MISS: begin
                if (fill_done) begin
                    state_nx = ST_READY;
                end
            end
            default: state_nx = ST_READY;
        endcase
    end

    // the first write beat leaves in the miss cycle, before pending is loaded
    assign mem_wr_valid = (miss_start && r_victim_dirty) || (state == ST_EVICT);
    assign mem_wr_addr  = (miss_start ? r_wr_base : p_wr_base) + beat_addr_t'(wr_cnt);
    assign mem_wr_data  = arr.victim_data;
    assign mem_rd_valid = (state == ST_MISS) && !rd_req_done;
    assign mem_rd_addr  = p_rd_base + beat_addr_t'(rd_req_cnt);

    assign arr.lookup_en   = accept;
    assign arr.lookup_addr = req_addr;

    // hits are served in the acceptance cycle, misses after the fill
    assign arr.store_en    = (accept && req_write && arr.hit) || (fill_done && p_write);
    assign arr.store_way   = fill_done ? p_way : arr.hit_way;
    assign arr.store_addr  = fill_done ? p_addr : req_addr;
    assign arr.store_size  = fill_done ? p_size : req_size;
    assign arr.store_wdata = fill_done ? p_wdata : req_wdata;

    assign arr.rd_en       = (accept && !req_write && arr.hit) || (fill_done && !p_write);
    assign arr.rd_way      = fill_done ? p_way : arr.hit_way;
    assign arr.rd_addr     = fill_done ? p_addr : req_addr;
    assign arr.rd_size     = fill_done ? p_size : req_size;
    assign arr.rd_unsigned = fill_done ? p_unsigned : req_unsigned;

    assign cur_addr        = miss_start ? r_addr : p_addr;
    assign arr.fill_en     = mem_rsp_valid;
    assign arr.fill_way    = miss_start ? r_victim_way : p_way;
    assign arr.fill_set    = cur_addr[OFF_W +: IDX_W];
    assign arr.fill_beat   = rd_rsp_cnt;
    assign arr.fill_data   = mem_rsp_data;
    assign arr.fill_last   = mem_rsp_valid && (rd_rsp_cnt == LAST_BEAT);
    assign arr.fill_tag    = p_addr[CORE_ADDR_W-1 -: TAG_W];
    assign arr.victim_beat = wr_cnt;

endmodule

// File: hdl/dcache.sv
`timescale 1ns/1ps

module dcache #(
    parameter int SETS = 8,
    parameter int WAYS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  logic                   req_write,
    input  dcache_pkg::core_addr_t req_addr,
    input  dcache_pkg::word_t      req_wdata,
    input  dcache_pkg::mem_size_t  req_size,
    input  logic                   req_unsigned,
    output logic                   req_ready,
    output logic                   rsp_valid,
    output dcache_pkg::word_t      rsp_data,
    output logic                   mem_rd_valid,
    output dcache_pkg::beat_addr_t mem_rd_addr,
    output logic                   mem_wr_valid,
    output dcache_pkg::beat_addr_t mem_wr_addr,
    output dcache_pkg::beat_t      mem_wr_data,
    input  logic                   mem_rsp_valid,
    input  dcache_pkg::beat_t      mem_rsp_data
);

    dcache_array_if #(.SETS(SETS), .WAYS(WAYS)) arr ();

    dcache_ctrl #(.SETS(SETS), .WAYS(WAYS)) u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_size      (req_size),
        .req_unsigned  (req_unsigned),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_addr   (mem_rd_addr),
        .mem_wr_valid  (mem_wr_valid),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data),
        .arr           (arr.ctrl)
    );

    dcache_tags #(.SETS(SETS), .WAYS(WAYS)) u_tags (
        .clk (clk),
        .rst (rst),
        .arr (arr.tags)
    );

    dcache_data #(.SETS(SETS), .WAYS(WAYS)) u_data (
        .clk (clk),
        .arr (arr.data)
    );

    // load result is registered in the data array
    assign rsp_data = arr.rd_data;

endmodule

// File: dv/dcache_mem_model.sv
`timescale 1ns/1ps

module dcache_mem_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rd_valid,
    input  dcache_pkg::beat_addr_t rd_addr,
    input  logic                   wr_valid,
    input  dcache_pkg::beat_addr_t wr_addr,
    input  dcache_pkg::beat_t      wr_data,
    output logic                   rsp_valid,
    output dcache_pkg::beat_t      rsp_data
);
    import dcache_pkg::*;

    logic [7:0] mem [0:(1 << CORE_ADDR_W) - 1];
    logic       pipe_valid;
    beat_addr_t pipe_addr;

    initial begin
        for (int a = 0; a < (1 << CORE_ADDR_W); a++) begin
            mem[a] = 8'((a * 29) ^ (a >> 7) ^ (a >> 13) ^ 'ha5);
        end
    end

    // request stage, then the beat comes back one cycle later
    always @(posedge clk) begin
        if (rst) begin
            pipe_valid <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            pipe_valid <= rd_valid;
            rsp_valid  <= pipe_valid;
        end
    end

    always @(posedge clk) begin
        pipe_addr <= rd_addr;
        for (int i = 0; i < BEAT_W / 8; i++) begin
            if (pipe_valid) begin
                rsp_data[i * 8 +: 8] <= mem[{pipe_addr, 4'(i)}];
            end
            if (wr_valid) begin
                mem[{wr_addr, 4'(i)}] <= wr_data[i * 8 +: 8];
            end
        end
    end

endmodule

// File: dv/tb_dcache.sv
`timescale 1ns/1ps

module tb_dcache;
    import dcache_pkg::*;

    localparam int SETS  = 4;
    localparam int WAYS  = 2;
    localparam int OFF_W = $clog2(LINE_BYTES);
    localparam int IDX_W = $clog2(SETS);
    localparam int N_OPS = 300;
    // a random store brings its read-back, the LRU sequence adds four
    localparam int          N_REQS     = 2 * N_OPS + 4;
    localparam int          MAX_CYCLES = 40 * N_REQS + 200;
    localparam logic [31:0] SEED       = 32'h0b221f57;

    logic       clk = 1'b0;
    logic       rst;
    logic       req_valid;
    logic       req_write;
    core_addr_t req_addr;
    word_t      req_wdata;
    mem_size_t  req_size;
    logic       req_unsigned;
    logic       req_ready;
    logic       rsp_valid;
    word_t      rsp_data;
    logic       mem_rd_valid;
    beat_addr_t mem_rd_addr;
    logic       mem_wr_valid;
    beat_addr_t mem_wr_addr;
    beat_t      mem_wr_data;
    logic       mem_rsp_valid;
    beat_t      mem_rsp_data;

    // reference memory and per-set shadow of the tag state
    logic [7:0] ref_mem  [0:(1 << CORE_ADDR_W) - 1];
    logic       sh_valid [SETS][WAYS];
    logic       sh_dirty [SETS][WAYS];
    int         sh_tag   [SETS][WAYS];
    int         sh_lru   [SETS][WAYS];

    beat_addr_t wb_addr_q[$];
    beat_t      wb_data_q[$];
    int         wb_cyc_q[$];
    beat_addr_t rd_addr_q[$];
    int         rd_cyc_q[$];
    beat_addr_t last_wb_base;
    int         cycles = 0;
    logic [31:0] rnd;

    dcache #(.SETS(SETS), .WAYS(WAYS)) dut (
        .clk           (clk),
        .rst           (rst),
        .req_valid     (req_valid),
        .req_write     (req_write),
        .req_addr      (req_addr),
        .req_wdata     (req_wdata),
        .req_size      (req_size),
        .req_unsigned  (req_unsigned),
        .req_ready     (req_ready),
        .rsp_valid     (rsp_valid),
        .rsp_data      (rsp_data),
        .mem_rd_valid  (mem_rd_valid),
        .mem_rd_addr   (mem_rd_addr),
        .mem_wr_valid  (mem_wr_valid),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_data  (mem_rsp_data)
    );

    dcache_mem_model u_mem (
        .clk       (clk),
        .rst       (rst),
        .rd_valid  (mem_rd_valid),
        .rd_addr   (mem_rd_addr),
        .wr_valid  (mem_wr_valid),
        .wr_addr   (mem_wr_addr),
        .wr_data   (mem_wr_data),
        .rsp_valid (mem_rsp_valid),
        .rsp_data  (mem_rsp_data)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // collect memory beats for the request that caused them
    always @(negedge clk) begin
        if (!rst && mem_wr_valid) begin
            wb_addr_q.push_back(mem_wr_addr);
            wb_data_q.push_back(mem_wr_data);
            wb_cyc_q.push_back(cycles);
        end
        if (!rst && mem_rd_valid) begin
            rd_addr_q.push_back(mem_rd_addr);
            rd_cyc_q.push_back(cycles);
        end
    end

    task automatic value_error(input string name, input beat_t exp, input beat_t act);
        $display("FAILED %s: expected %0h, actual %0h", name, exp, act);
        $display("Test failed");
        $fatal(1, "stopped at the first mismatch");
    endtask

    task automatic protocol_error(input string what);
        $display("ERROR: %s", what);
        $display("Test failed");
        $fatal(1, "stopped at the first protocol error");
    endtask

    function automatic core_addr_t line_addr(input int tag, input int set);
        return core_addr_t'((tag * SETS + set) * LINE_BYTES);
    endfunction

    function automatic word_t expected_load(input core_addr_t a, input mem_size_t size,
                                            input logic uns);
        logic [15:0] h;
        h = {ref_mem[a + 1], ref_mem[a]};
        case (size)
            SIZE_BYTE: return uns ? {24'b0, h[7:0]} : {{24{h[7]}}, h[7:0]};
            SIZE_HALF: return uns ? {16'b0, h} : {{16{h[15]}}, h};
            default:   return {ref_mem[a + 3], ref_mem[a + 2], h};
        endcase
    endfunction

    function automatic beat_t model_beat(input beat_addr_t ba);
        beat_t b;
        for (int i = 0; i < BEAT_W / 8; i++) begin
            b[i * 8 +: 8] = ref_mem[{ba, 4'(i)}];
        end
        return b;
    endfunction

    // touched way becomes newest, younger ways age by one
    task automatic touch(input int set, input int way);
        int old;
        old = sh_lru[set][way];
        for (int w = 0; w < WAYS; w++) begin
            if (sh_lru[set][w] < old) begin
                sh_lru[set][w]++;
            end
        end
        sh_lru[set][way] = 0;
    endtask

    task automatic access(input string name, input logic wr, input core_addr_t a,
                          input word_t wdata, input mem_size_t size, input logic uns);
        int         set;
        int         tag;
        int         way;
        int         n;
        logic       hit;
        logic       wb_exp;
        beat_addr_t wb_base;
        beat_addr_t rd_base;
        word_t      exp;
        set     = int'(a[OFF_W +: IDX_W]);
        tag     = int'(a >> (OFF_W + IDX_W));
        hit     = 1'b0;
        way     = 0;
        wb_exp  = 1'b0;
        wb_base = '0;
        rd_base = beat_addr_t'(line_addr(tag, set) / (BEAT_W / 8));
        exp     = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (sh_valid[set][w] && sh_tag[set][w] == tag) begin
                hit = 1'b1;
                way = w;
            end
        end
        if (!hit) begin
            for (int w = 0; w < WAYS; w++) begin
                if (sh_lru[set][w] == WAYS - 1) begin
                    way = w;
                end
            end
            wb_exp  = sh_valid[set][way] && sh_dirty[set][way];
            wb_base = beat_addr_t'(line_addr(sh_tag[set][way], set) / (BEAT_W / 8));
            sh_valid[set][way] = 1'b1;
            sh_dirty[set][way] = 1'b0;
            sh_tag[set][way]   = tag;
        end
        if (wr) begin
            sh_dirty[set][way] = 1'b1;
            touch(set, way);
            for (int i = 0; i < (1 << int'(size)); i++) begin
                ref_mem[a + i] = wdata[i * 8 +: 8];
            end
        end else begin
            // a load miss leaves the LRU order unchanged
            if (hit) begin
                touch(set, way);
            end
            exp = expected_load(a, size, uns);
        end

        @(posedge clk);
        req_valid    <= 1'b1;
        req_write    <= wr;
        req_addr     <= a;
        req_wdata    <= wdata;
        req_size     <= size;
        req_unsigned <= uns;
        @(negedge clk);
        assert (req_ready) else protocol_error({name, ": cache not ready for a request"});
        @(posedge clk);
        req_valid <= 1'b0;
        @(negedge clk);
        assert (req_ready == hit) else value_error({name, " ready after accept"}, hit, req_ready);

        if (wr) begin
            assert (!rsp_valid) else protocol_error({name, ": response to a store"});
            while (!req_ready) begin
                @(negedge clk);
                assert (!rsp_valid) else protocol_error({name, ": response to a store"});
            end
        end else begin
            n = 1;
            while (!rsp_valid) begin
                @(negedge clk);
                n++;
            end
            if (hit) begin
                assert (n == 1) else value_error({name, " hit latency"}, 1, BEAT_W'(n));
            end
            assert (req_ready) else protocol_error({name, ": response while not ready"});
            assert (rsp_data == exp) else value_error(name, exp, rsp_data);
            @(negedge clk);
            assert (!rsp_valid) else protocol_error({name, ": response longer than a cycle"});
        end

        if (wb_addr_q.size() > 0) begin
            last_wb_base = wb_addr_q[0];
        end
        if (wb_exp) begin
            assert (wb_addr_q.size() == BEATS_PER_LINE)
                else protocol_error({name, ": write-back burst is not four beats"});
            for (int i = 0; i < BEATS_PER_LINE; i++) begin
                assert (wb_addr_q[i] == wb_base + beat_addr_t'(i))
                    else value_error({name, " write-back addr"}, wb_base + beat_addr_t'(i),
                                     wb_addr_q[i]);
                assert (wb_data_q[i] == model_beat(wb_addr_q[i]))
                    else value_error({name, " write-back data"}, model_beat(wb_addr_q[i]),
                                     wb_data_q[i]);
                assert (wb_cyc_q[i] == wb_cyc_q[0] + i)
                    else protocol_error({name, ": write-back beats not back to back"});
            end
        end else begin
            assert (wb_addr_q.size() == 0)
                else protocol_error({name, ": write-back without a dirty victim"});
        end

        // a miss reads the whole line of the request, a hit reads nothing
        if (hit) begin
            assert (rd_addr_q.size() == 0)
                else protocol_error({name, ": memory read on a hit"});
        end else begin
            assert (rd_addr_q.size() == BEATS_PER_LINE)
                else protocol_error({name, ": line fill is not four read beats"});
            for (int i = 0; i < BEATS_PER_LINE; i++) begin
                assert (rd_addr_q[i] == rd_base + beat_addr_t'(i))
                    else value_error({name, " fill addr"}, rd_base + beat_addr_t'(i),
                                     rd_addr_q[i]);
                assert (rd_cyc_q[i] == rd_cyc_q[0] + i)
                    else protocol_error({name, ": read beats not back to back"});
            end
        end
        wb_addr_q.delete();
        wb_data_q.delete();
        wb_cyc_q.delete();
        rd_addr_q.delete();
        rd_cyc_q.delete();
    endtask

    initial begin
        int         idx;
        int         sz;
        core_addr_t a;
        core_addr_t line_b;
        mem_size_t  size;
        rnd = $urandom(SEED);
        for (int i = 0; i < (1 << CORE_ADDR_W); i++) begin
            ref_mem[i] = 8'((i * 29) ^ (i >> 7) ^ (i >> 13) ^ 'ha5);
        end
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                sh_valid[s][w] = 1'b0;
                sh_dirty[s][w] = 1'b0;
                sh_tag[s][w]   = 0;
                sh_lru[s][w]   = w;
            end
        end
        rst          = 1'b1;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_addr     = '0;
        req_wdata    = '0;
        req_size     = SIZE_WORD;
        req_unsigned = 1'b0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        assert (req_ready && !rsp_valid && !mem_rd_valid && !mem_wr_valid)
            else protocol_error("outputs not idle after reset");

        // set 2 is kept for this sequence, B is dirty and older than A when C misses
        line_b = line_addr(65, 2);
        access("lru store A", 1'b1, line_addr(64, 2), 32'h1111_0001, SIZE_WORD, 1'b0);
        access("lru store B", 1'b1, line_b + 16'd8, 32'h2222_0002, SIZE_WORD, 1'b0);
        access("lru touch A", 1'b1, line_addr(64, 2) + 16'd5, 32'h33, SIZE_BYTE, 1'b0);
        last_wb_base = '1;
        access("lru miss C", 1'b0, line_addr(66, 2), '0, SIZE_WORD, 1'b0);
        assert (last_wb_base == beat_addr_t'(line_b / 16))
            else value_error("lru victim", beat_addr_t'(line_b / 16), last_wb_base);

        // 24 lines in sets 0 and 1 keep both ways busy
        for (int k = 0; k < N_OPS; k++) begin
            idx  = int'($urandom % 24);
            sz   = int'($urandom % 3);
            size = mem_size_t'(sz);
            a    = line_addr(idx / 2 + 16, idx % 2)
                 + core_addr_t'(($urandom % (LINE_BYTES >> sz)) << sz);
            if ($urandom % 2 == 1) begin
                access($sformatf("store %0d", k), 1'b1, a, $urandom, size, 1'b0);
                access($sformatf("readback %0d", k), 1'b0, {a[CORE_ADDR_W-1:2], 2'b00}, '0,
                       SIZE_WORD, 1'b0);
            end else begin
                access($sformatf("load %0d", k), 1'b0, a, '0, size, 1'($urandom % 2));
            end
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: all.f
hdl/dcache_pkg.sv
hdl/dcache_array_if.sv
hdl/dcache_tags.sv
hdl/dcache_data.sv
hdl/dcache_ctrl.sv
hdl/dcache.sv
dv/dcache_mem_model.sv
dv/tb_dcache.sv

// File: Bender.yml
package:
  name: dcache

sources:
  - hdl/dcache_pkg.sv
  - hdl/dcache_array_if.sv
  - hdl/dcache_tags.sv
  - hdl/dcache_data.sv
  - hdl/dcache_ctrl.sv
  - hdl/dcache.sv
  - target: test
    files:
      - dv/dcache_mem_model.sv
      - dv/tb_dcache.sv
